/* include/pipe_macros.svh */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data path and register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DATA_W      32   // integer data path width
`define REG_AW      5    // general register address width
`define REG_COUNT   32   // number of general registers

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DMEM_WORDS  256  // default depth in words, one word per index

`endif

/* hdl/pipe_pkg.sv */
`include "pipe_macros.svh"

package pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,  // alu result passes straight through
        MEM_LW   = 4'd1,
        MEM_LH   = 4'd2,  // halfword, sign extended
        MEM_LHU  = 4'd3,
        MEM_LB   = 4'd4,  // byte, sign extended
        MEM_LBU  = 4'd5,
        MEM_SW   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SB   = 4'd8
    } mem_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory to write-back bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        mem_op_t             op;
        logic [1:0]          byte_sel;  // low address bits of the access
        logic                gr_we;
        logic [`REG_AW-1:0]  dest;
        logic [`DATA_W-1:0]  result;    // load word or alu result
        logic [`DATA_W-1:0]  pc;
    } ms_to_ws_t;

endpackage

/* hdl/stage_if.sv */
`timescale 1ns/1ps

// one pipeline stage boundary with a valid/allowin handshake
interface stage_if ();
    import pipe_pkg::*;

    logic       valid;    // sending stage holds an entry for the receiver
    logic       allowin;  // receiving stage can take an entry this cycle
    ms_to_ws_t  bus;

    // the sending stage
    modport source (
        output valid,
        output bus,
        input  allowin
    );

    // the receiving stage
    modport sink (
        input  valid,
        input  bus,
        output allowin
    );

endinterface

/* hdl/mem_stage.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module mem_stage #(
    parameter int DMEM_WORDS = `DMEM_WORDS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_allowin,
    input  pipe_pkg::mem_op_t   in_op,
    input  logic [`DATA_W-1:0]  in_result,
    input  logic [`DATA_W-1:0]  in_store_data,
    input  logic [`REG_AW-1:0]  in_dest,
    input  logic                in_gr_we,
    input  logic [`DATA_W-1:0]  in_pc,
    stage_if.source             ms_to_ws
);
    import pipe_pkg::*;

    localparam int MEM_AW = $clog2(DMEM_WORDS);

    logic                ms_valid;
    logic                in_fire;
    logic                in_is_load;
    logic                in_is_store;
    logic                ms_is_load;
    mem_op_t             ms_op;
    logic                ms_gr_we;
    logic [`REG_AW-1:0]  ms_dest;
    logic [`DATA_W-1:0]  ms_result;
    logic [`DATA_W-1:0]  ms_pc;
    logic [`DATA_W-1:0]  load_word;
    logic [MEM_AW-1:0]   word_addr;
    logic [3:0]          byte_en;
    logic [`DATA_W-1:0]  store_lane;

    logic [`DATA_W-1:0]  dmem [DMEM_WORDS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake and pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_allowin = !ms_valid || ms_to_ws.allowin;  // entry leaves as a new one arrives
    assign in_fire    = in_valid && in_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (in_allowin) begin
            ms_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            ms_op     <= in_op;
            ms_gr_we  <= in_gr_we && !in_is_store;  // stores never write a register
            ms_dest   <= in_dest;
            ms_result <= in_result;
            ms_pc     <= in_pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_is_load  = in_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
    assign in_is_store = in_op inside {MEM_SW, MEM_SH, MEM_SB};
    assign ms_is_load  = ms_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
    assign word_addr   = in_result[MEM_AW+1:2];
    assign store_lane  = in_store_data << {in_result[1:0], 3'b000};  // move data to its lane

    always_comb begin
        case (in_op)
            MEM_SW:  byte_en = 4'b1111;
            MEM_SH:  byte_en = in_result[1] ? 4'b1100 : 4'b0011;
            MEM_SB:  byte_en = 4'b0001 << in_result[1:0];
            default: byte_en = 4'b0000;
        endcase
    end

    // the read happens only on acceptance so a stall keeps the load word
    always_ff @(posedge clk) begin
        if (in_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem[word_addr][8*i +: 8] <= store_lane[8*i +: 8];
                end
            end
            if (in_is_load) begin
                load_word <= dmem[word_addr];
            end
        end
    end

    assign ms_to_ws.valid = ms_valid;
    assign ms_to_ws.bus   = '{op:       ms_op,
                              byte_sel: ms_result[1:0],
                              gr_we:    ms_gr_we,
                              dest:     ms_dest,
                              result:   ms_is_load ? load_word : ms_result,
                              pc:       ms_pc};

    // upstream must hand over naturally aligned accesses
    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        in_fire && (in_op inside {MEM_LH, MEM_LHU, MEM_SH}) |-> !in_result[0])
        else $error("misaligned halfword access at %h", in_result);

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        in_fire && (in_op inside {MEM_LW, MEM_SW}) |-> in_result[1:0] == 2'b00)
        else $error("misaligned word access at %h", in_result);

    a_store_no_we: assert property (@(posedge clk) disable iff (reset)
        in_fire && in_is_store |-> !in_gr_we)
        else $error("store request carries a register write enable");

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module wb_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                commit_hold,
    stage_if.sink               ms_to_ws,
    output logic                rf_wen,
    output logic [`REG_AW-1:0]  rf_waddr,
    output logic [`DATA_W-1:0]  rf_wdata,
    output logic [`DATA_W-1:0]  wb_forward,
    output logic [`DATA_W-1:0]  debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output logic [`REG_AW-1:0]  debug_wb_rf_wnum,
    output logic [`DATA_W-1:0]  debug_wb_rf_wdata
);
    import pipe_pkg::*;

    logic                ws_valid;
    logic                ws_ready_go;
    logic                ws_allowin;
    ms_to_ws_t           ws_bus;
    logic [15:0]         sel_half;
    logic [7:0]          sel_byte;
    logic [`DATA_W-1:0]  final_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ws_ready_go       = !commit_hold;  // the trace side can stall commit
    assign ws_allowin        = !ws_valid || ws_ready_go;
    assign ms_to_ws.allowin  = ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws.valid && ws_allowin) begin
            ws_bus <= ms_to_ws.bus;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load extract and extend
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sel_half = ws_bus.byte_sel[1] ? ws_bus.result[31:16] : ws_bus.result[15:0];
    assign sel_byte = ws_bus.result[{ws_bus.byte_sel, 3'b000} +: 8];

    always_comb begin
        case (ws_bus.op)
            MEM_LH:  final_result = {{16{sel_half[15]}}, sel_half};
            MEM_LHU: final_result = {16'h0000, sel_half};
            MEM_LB:  final_result = {{24{sel_byte[7]}}, sel_byte};
            MEM_LBU: final_result = {24'h000000, sel_byte};
            default: final_result = ws_bus.result;  // word loads and alu results
        endcase
    end

    // commit happens on the edge where the entry also leaves
    assign rf_wen   = ws_bus.gr_we && ws_valid && !commit_hold;
    assign rf_waddr = ws_bus.dest;
    assign rf_wdata = final_result;

    assign wb_forward = final_result;

    assign debug_wb_pc       = ws_bus.pc;
    assign debug_wb_rf_wen   = {4{rf_wen}};
    assign debug_wb_rf_wnum  = ws_bus.dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                wen,
    input  logic [`REG_AW-1:0]  waddr,
    input  logic [`DATA_W-1:0]  wdata,
    input  logic [`REG_AW-1:0]  raddr,
    output logic [`DATA_W-1:0]  rdata
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;  // register 0 is hard wired
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rdata = (raddr == '0) ? '0 : regs[raddr];  // combinational read

    // a write aimed at register 0 leaves every register as it was
    a_r0_write_silent: assert property (@(posedge clk) disable iff (reset)
        wen && waddr == '0 |=> ($stable(raddr) -> $stable(rdata)))
        else $error("write to register 0 changed read data at r%0d", raddr);

endmodule

/* hdl/lsu_pipe_top.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module lsu_pipe_top (
    input  logic                clk,
    input  logic                reset,
    // request side
    input  logic                in_valid,
    output logic                in_allowin,
    input  pipe_pkg::mem_op_t   in_op,
    input  logic [`DATA_W-1:0]  in_result,
    input  logic [`DATA_W-1:0]  in_store_data,
    input  logic [`REG_AW-1:0]  in_dest,
    input  logic                in_gr_we,
    input  logic [`DATA_W-1:0]  in_pc,
    // commit control and register read-back
    input  logic                commit_hold,
    input  logic [`REG_AW-1:0]  rf_raddr,
    output logic [`DATA_W-1:0]  rf_rdata,
    output logic [`DATA_W-1:0]  wb_forward,
    // trace
    output logic [`DATA_W-1:0]  debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output logic [`REG_AW-1:0]  debug_wb_rf_wnum,
    output logic [`DATA_W-1:0]  debug_wb_rf_wdata
);

    logic                rf_wen;
    logic [`REG_AW-1:0]  rf_waddr;
    logic [`DATA_W-1:0]  rf_wdata;

    stage_if ms_ws_if ();

    mem_stage #(
        .DMEM_WORDS (`DMEM_WORDS)
    ) u_mem_stage (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_allowin    (in_allowin),
        .in_op         (in_op),
        .in_result     (in_result),
        .in_store_data (in_store_data),
        .in_dest       (in_dest),
        .in_gr_we      (in_gr_we),
        .in_pc         (in_pc),
        .ms_to_ws      (ms_ws_if.source)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .reset             (reset),
        .commit_hold       (commit_hold),
        .ms_to_ws          (ms_ws_if.sink),
        .rf_wen            (rf_wen),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .wb_forward        (wb_forward),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .wen   (rf_wen),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

/* tests/lsu_pipe_checker.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module lsu_pipe_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  logic                in_allowin,
    input  logic [`REG_AW-1:0]  rf_raddr,
    input  logic [`DATA_W-1:0]  rf_rdata,
    input  logic [`DATA_W-1:0]  wb_forward,
    input  logic [`DATA_W-1:0]  debug_wb_pc,
    input  logic [3:0]          debug_wb_rf_wen,
    input  logic [`REG_AW-1:0]  debug_wb_rf_wnum,
    input  logic [`DATA_W-1:0]  debug_wb_rf_wdata
);

    typedef struct packed {
        logic [15:0]         row;
        logic [`DATA_W-1:0]  pc;
        logic [`REG_AW-1:0]  dest;
        logic                we;
        logic [`DATA_W-1:0]  data;
    } exp_row_t;

    exp_row_t            rows_q [$];                  // accepted rows still to commit
    logic [`DATA_W-1:0]  reg_model [`REG_COUNT];
    int                  pass_count = 0;
    int                  fail_count = 0;
    int                  err_count = 0;
    int                  pending_we = 0;              // queued rows that still owe a write
    int                  stall_cycles = 0;

    initial begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            reg_model[i] = '0;
        end
    end

    task automatic push_row(input int row, input logic [`DATA_W-1:0] pc,
                            input logic [`REG_AW-1:0] dest, input logic we,
                            input logic [`DATA_W-1:0] data);
        rows_q.push_back('{row: row[15:0], pc: pc, dest: dest, we: we, data: data});
        if (we) begin
            pending_we++;
        end
        if (we && dest != '0) begin
            reg_model[dest] = data;  // register 0 stays zero
        end
    endtask

    function automatic int check_field(input int row, input string name,
                                       input logic [`DATA_W-1:0] got,
                                       input logic [`DATA_W-1:0] expected);
        if (got !== expected) begin
            $display("ERROR row %0d %s: got %h, expected %h", row, name, got, expected);
            return 1;
        end
        return 0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write-back trace
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_write();
        exp_row_t  r;
        int        errs;
        bit        done;
        done = 0;
        if (debug_wb_rf_wen !== 4'hf) begin
            $display("ERROR debug_wb_rf_wen: got %h, expected %h", debug_wb_rf_wen, 4'hf);
            err_count++;
        end
        while (!done && rows_q.size() > 0 && !rows_q[0].we) begin
            r = rows_q.pop_front();
            if (r.pc == debug_wb_pc) begin  // a row that should not write did
                $display("row %0d: fail, wrote r%0d without a write enable", r.row,
                         debug_wb_rf_wnum);
                fail_count++;
                done = 1;
            end else begin
                $display("row %0d: pass, no write-back", r.row);
                pass_count++;
            end
        end
        if (!done && rows_q.size() == 0) begin
            $display("write-back at pc %h arrived with no request outstanding", debug_wb_pc);
            err_count++;
        end else if (!done) begin
            r = rows_q.pop_front();
            pending_we--;
            errs = check_field(r.row, "debug_wb_pc", debug_wb_pc, r.pc);
            errs += check_field(r.row, "debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum},
                                {27'd0, r.dest});
            errs += check_field(r.row, "debug_wb_rf_wdata", debug_wb_rf_wdata, r.data);
            errs += check_field(r.row, "wb_forward", wb_forward, r.data);
            if (errs == 0) begin
                $display("row %0d: pass, r%0d = %h", r.row, r.dest, r.data);
                pass_count++;
            end else begin
                $display("row %0d: fail", r.row);
                fail_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (in_valid && !in_allowin) begin
                stall_cycles++;  // both stages full under hold
            end
            if (debug_wb_rf_wen !== 4'h0) begin
                check_write();
            end
        end
    end

    // rows left after the drain must be ones that never write
    task automatic finish_checks();
        exp_row_t r;
        while (rows_q.size() > 0) begin
            r = rows_q.pop_front();
            if (r.we) begin
                $display("row %0d: fail, its write-back never appeared", r.row);
                fail_count++;
            end else begin
                $display("row %0d: pass, no write-back", r.row);
                pass_count++;
            end
        end
        if (stall_cycles == 0) begin
            $display("in_allowin never dropped while the commit hold was applied");
            err_count++;
        end
    endtask

    task automatic check_read();
        logic [`DATA_W-1:0] expected;
        expected = reg_model[rf_raddr];
        if (rf_rdata !== expected) begin
            $display("ERROR rf_rdata r%0d: got %h, expected %h", rf_raddr, rf_rdata, expected);
            $display("read r%0d: fail", rf_raddr);
            fail_count++;
        end else begin
            $display("read r%0d: pass, %h", rf_raddr, rf_rdata);
            pass_count++;
        end
    endtask

endmodule

/* tests/lsu_pipe_tb.sv */
`timescale 1ns/1ps
`include "pipe_macros.svh"

module lsu_pipe_tb;
    import pipe_pkg::*;

    localparam int ROWS         = 28;
    localparam int MAX_HOLD_RUN = 3;
    localparam int TIMEOUT_CYCLES = ROWS * (3 + MAX_HOLD_RUN) + `REG_COUNT + 20;

    typedef struct packed {
        mem_op_t             op;
        logic [`DATA_W-1:0]  addr;      // address for memory ops, result otherwise
        logic [`DATA_W-1:0]  sdata;
        logic [`REG_AW-1:0]  dest;
        logic                gr_we;
        logic [`DATA_W-1:0]  exp_data;
        logic                exp_we;
    } stim_row_t;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_allowin;
    mem_op_t             in_op;
    logic [`DATA_W-1:0]  in_result;
    logic [`DATA_W-1:0]  in_store_data;
    logic [`REG_AW-1:0]  in_dest;
    logic                in_gr_we;
    logic [`DATA_W-1:0]  in_pc;
    logic                commit_hold;
    logic [`REG_AW-1:0]  rf_raddr;
    logic [`DATA_W-1:0]  rf_rdata;
    logic [`DATA_W-1:0]  wb_forward;
    logic [`DATA_W-1:0]  debug_wb_pc;
    logic [3:0]          debug_wb_rf_wen;
    logic [`REG_AW-1:0]  debug_wb_rf_wnum;
    logic [`DATA_W-1:0]  debug_wb_rf_wdata;

    stim_row_t           stim [ROWS];
    logic [31:0]         lcg_state;
    int                  hold_left;
    int                  cycle_count = 0;

    lsu_pipe_top dut (.*);

    lsu_pipe_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the pipeline did not drain", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_table();
        // op, address or result, store data, dest, gr_we, expected data, expected we
        stim[0]  = '{MEM_NONE, 32'h1234_5678, 32'h0, 5'd1,  1'b1, 32'h1234_5678, 1'b1};
        stim[1]  = '{MEM_NONE, 32'hdead_beef, 32'h0, 5'd2,  1'b1, 32'hdead_beef, 1'b1};
        stim[2]  = '{MEM_NONE, 32'h0000_00aa, 32'h0, 5'd3,  1'b0, 32'h0,         1'b0};
        stim[3]  = '{MEM_NONE, 32'hffff_ffff, 32'h0, 5'd0,  1'b1, 32'hffff_ffff, 1'b1};
        stim[4]  = '{MEM_SW,   32'h0000_0040, 32'hcafe_f00d, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[5]  = '{MEM_LW,   32'h0000_0040, 32'h0, 5'd4,  1'b1, 32'hcafe_f00d, 1'b1};
        stim[6]  = '{MEM_SW,   32'h0000_0080, 32'h8001_7f02, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[7]  = '{MEM_LH,   32'h0000_0080, 32'h0, 5'd5,  1'b1, 32'h0000_7f02, 1'b1};
        stim[8]  = '{MEM_LHU,  32'h0000_0080, 32'h0, 5'd6,  1'b1, 32'h0000_7f02, 1'b1};
        stim[9]  = '{MEM_LH,   32'h0000_0082, 32'h0, 5'd7,  1'b1, 32'hffff_8001, 1'b1};
        stim[10] = '{MEM_LHU,  32'h0000_0082, 32'h0, 5'd8,  1'b1, 32'h0000_8001, 1'b1};
        stim[11] = '{MEM_SB,   32'h0000_00c0, 32'h1234_5685, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[12] = '{MEM_SB,   32'h0000_00c1, 32'h1234_567a, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[13] = '{MEM_SB,   32'h0000_00c2, 32'h1234_56f0, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[14] = '{MEM_SB,   32'h0000_00c3, 32'h1234_5601, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[15] = '{MEM_LB,   32'h0000_00c0, 32'h0, 5'd9,  1'b1, 32'hffff_ff85, 1'b1};
        stim[16] = '{MEM_LBU,  32'h0000_00c0, 32'h0, 5'd10, 1'b1, 32'h0000_0085, 1'b1};
        stim[17] = '{MEM_LB,   32'h0000_00c1, 32'h0, 5'd11, 1'b1, 32'h0000_007a, 1'b1};
        stim[18] = '{MEM_LBU,  32'h0000_00c1, 32'h0, 5'd12, 1'b1, 32'h0000_007a, 1'b1};
        stim[19] = '{MEM_LB,   32'h0000_00c2, 32'h0, 5'd13, 1'b1, 32'hffff_fff0, 1'b1};
        stim[20] = '{MEM_LBU,  32'h0000_00c2, 32'h0, 5'd14, 1'b1, 32'h0000_00f0, 1'b1};
        stim[21] = '{MEM_LB,   32'h0000_00c3, 32'h0, 5'd15, 1'b1, 32'h0000_0001, 1'b1};
        stim[22] = '{MEM_LBU,  32'h0000_00c3, 32'h0, 5'd16, 1'b1, 32'h0000_0001, 1'b1};
        stim[23] = '{MEM_SH,   32'h0000_00c2, 32'h0000_beef, 5'd0, 1'b0, 32'h0, 1'b0};
        stim[24] = '{MEM_LW,   32'h0000_00c0, 32'h0, 5'd17, 1'b1, 32'hbeef_7a85, 1'b1};
        stim[25] = '{MEM_NONE, 32'h0bad_cafe, 32'h0, 5'd1,  1'b1, 32'h0bad_cafe, 1'b1};
        stim[26] = '{MEM_LW,   32'h0000_0040, 32'h0, 5'd2,  1'b1, 32'hcafe_f00d, 1'b1};
        stim[27] = '{MEM_NONE, 32'h5555_aaaa, 32'h0, 5'd18, 1'b1, 32'h5555_aaaa, 1'b1};
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`DATA_W-1:0] row_pc(input int idx);
        return 32'h0000_1000 + (idx << 2);
    endfunction

    task automatic drive_request(input int idx);
        in_valid      = 1'b1;
        in_op         = stim[idx].op;
        in_result     = stim[idx].addr;
        in_store_data = stim[idx].sdata;
        in_dest       = stim[idx].dest;
        in_gr_we      = stim[idx].gr_we;
        in_pc         = row_pc(idx);
    endtask

    // hold runs of two or three cycles, with a free cycle after each run
    task automatic next_hold();
        lcg_state = lcg_next(lcg_state);
        if (hold_left > 0) begin
            commit_hold = 1'b1;
            hold_left--;
        end else if (!commit_hold && lcg_state[20]) begin
            commit_hold = 1'b1;
            hold_left = 1 + lcg_state[9];
        end else begin
            commit_hold = 1'b0;
        end
    endtask

    initial begin
        int row;
        in_valid      = 1'b0;
        in_op         = MEM_NONE;
        in_result     = '0;
        in_store_data = '0;
        in_dest       = '0;
        in_gr_we      = 1'b0;
        in_pc         = '0;
        commit_hold   = 1'b0;
        rf_raddr      = '0;
        reset         = 1'b1;
        lcg_state     = 32'he8c4;
        hold_left     = 0;
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        row = 0;
        while (row < ROWS) begin
            @(negedge clk);
            drive_request(row);
            if (row >= ROWS / 2) begin
                next_hold();
            end
            @(posedge clk);
            if (in_allowin) begin  // accepted on this edge
                chk.push_row(row, row_pc(row), stim[row].dest, stim[row].exp_we,
                             stim[row].exp_data);
                row++;
            end
        end

        @(negedge clk);
        in_valid    = 1'b0;
        commit_hold = 1'b0;
        hold_left   = 0;
        while (chk.pending_we != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        chk.finish_checks();

        for (int a = 0; a < `REG_COUNT; a++) begin
            @(negedge clk);
            rf_raddr = a[`REG_AW-1:0];
            @(posedge clk);
            chk.check_read();
        end

        $display("tests passed %0d, failed %0d, other errors %0d", chk.pass_count,
                 chk.fail_count, chk.err_count);
        if (chk.fail_count == 0 && chk.err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hdl/pipe_pkg.sv
hdl/stage_if.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/reg_file.sv
hdl/lsu_pipe_top.sv
tests/lsu_pipe_checker.sv
tests/lsu_pipe_tb.sv
